// ==== files.f ====
common/l1_trig_pkg.sv
trigger/beam_former.sv
trigger/beam_discriminator.sv
trigger/trigger_rate_counter.sv
logic/l1_trigger_regs.sv
logic/l1_trigger_top.sv
bench/tb_clock_gen.sv
bench/l1_trigger_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module l1_trigger_tb -Mdir obj_dir
	./obj_dir/Vl1_trigger_tb | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== bench/l1_trigger_tb.sv ====
`timescale 1ns/100ps

module l1_trigger_tb;
    import l1_trig_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_PHASES      = 5;
    localparam int WATCHDOG_CYCLES = NUM_PHASES * RATE_PERIOD_CLOCKS + 2000;

    logic          aclk;
    logic          rst_n;
    chan_samples_t samples;
    axil_req_t     axil_req;
    axil_rsp_t     axil_rsp;
    beam_mask_t    trigger_o;

    // Sample source mode: quiet, random, constant high
    int            mode;
    int            value_errors;
    int            proto_errors;
    logic          holdoff_phase;
    logic          count_en;
    int            pulse_cnt [NUM_BEAMS];
    int            hold_pulses [NUM_BEAMS];
    // Edge times of the latest bus acceptances
    longint        wr_acc_time;
    longint        rd_acc_time;

    // Reference model state
    int            hist_m [MAX_DELAY][NUM_CHANNELS];
    int            sum_m [NUM_BEAMS];
    int            pw_m [NUM_BEAMS];
    logic          raw_m [NUM_BEAMS];
    int            hold_m [NUM_BEAMS];
    threshold_t    stage_m [NUM_BEAMS];
    threshold_t    act_m [NUM_BEAMS];
    logic          upd_d;
    logic          start_d;
    beam_mask_t    exp_trig;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o (aclk)
    );

    l1_trigger_top l1_trigger_top_inst (
        .aclk       (aclk),
        .rst_n_i    (rst_n),
        .samples_i  (samples),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp),
        .trigger_o  (trigger_o)
    );

    //////////////////////////////////////////////////////////////
    // Sample source
    //////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (mode == 1) begin
                samples[c] <= sample_t'($urandom);
            end else if (mode == 2) begin
                samples[c] <= sample_t'(15);
            end else begin
                samples[c] <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////

    // Expected gated trigger for the current cycle
    always_comb begin
        for (int b = 0; b < NUM_BEAMS; b++) begin
            exp_trig[b] = raw_m[b] && (hold_m[b] == 0);
        end
    end

    // Stages are updated oldest first so each reads its input before it moves
    always @(posedge aclk) begin
        logic acc;
        int   tap;
        if (!rst_n) begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                sum_m[b]   = 0;
                pw_m[b]    = 0;
                raw_m[b]   = 1'b0;
                hold_m[b]  = 0;
                stage_m[b] = THRESH_RESET;
                act_m[b]   = THRESH_RESET;
            end
            for (int d = 0; d < MAX_DELAY; d++) begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    hist_m[d][c] = 0;
                end
            end
            upd_d   = 1'b0;
            start_d = 1'b0;
        end else begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                // Rate phase tally of the expected pulses
                if (count_en && exp_trig[b]) begin
                    pulse_cnt[b]++;
                end
                // Holdoff follows the pulse the DUT shows this cycle
                if (start_d) begin
                    hold_m[b] = 0;
                end else if (exp_trig[b]) begin
                    hold_m[b] = HOLDOFF_CLOCKS;
                end else if (hold_m[b] != 0) begin
                    hold_m[b] = hold_m[b] - 1;
                end
                raw_m[b] = (pw_m[b] > int'(act_m[b]));
                if (upd_d) begin
                    act_m[b] = stage_m[b];
                end
                pw_m[b]  = sum_m[b] * sum_m[b];
                sum_m[b] = 0;
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    if (BEAM_DELAYS[b][c] == 0) begin
                        tap = int'(samples[c]);
                    end else begin
                        tap = hist_m[BEAM_DELAYS[b][c] - 1][c];
                    end
                    sum_m[b] = sum_m[b] + tap;
                end
            end
            for (int d = MAX_DELAY - 1; d > 0; d--) begin
                hist_m[d] = hist_m[d-1];
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                hist_m[0][c] = int'(samples[c]);
            end
            // Bus writes accepted at this edge
            acc     = axil_req.awvalid && axil_req.wvalid && axil_rsp.awready
                      && axil_rsp.wready;
            upd_d   = acc && (axil_req.awaddr == REG_CTRL) && axil_req.wstrb[0]
                      && axil_req.wdata[1];
            start_d = acc && (axil_req.awaddr == REG_CTRL) && axil_req.wstrb[0]
                      && axil_req.wdata[0];
            for (int b = 0; b < NUM_BEAMS; b++) begin
                if (acc && axil_req.awaddr == axil_addr_t'(16 + 4 * b)) begin
                    if (axil_req.wstrb[0]) stage_m[b][7:0] = axil_req.wdata[7:0];
                    if (axil_req.wstrb[1]) stage_m[b][15:8] = axil_req.wdata[15:8];
                    if (axil_req.wstrb[2]) stage_m[b][17:16] = axil_req.wdata[17:16];
                end
            end
        end
    end

    // Pulse counter for the holdoff phase
    always @(posedge aclk) begin
        for (int b = 0; b < NUM_BEAMS; b++) begin
            if (holdoff_phase && trigger_o[b]) hold_pulses[b]++;
        end
    end

    //////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////

    trig_match: assert property (@(posedge aclk) disable iff (!rst_n)
        trigger_o == exp_trig)
    else begin
        value_errors++;
        $display("Fail at %0t: trigger_o %b expected %b", $time,
                 $sampled(trigger_o), $sampled(exp_trig));
    end

    bresp_okay: assert property (@(posedge aclk) disable iff (!rst_n)
        axil_rsp.bvalid |-> axil_rsp.bresp == AXIL_RESP_OKAY)
    else begin
        proto_errors++;
        $display("Write response at %0t is not OKAY", $time);
    end

    rresp_okay: assert property (@(posedge aclk) disable iff (!rst_n)
        axil_rsp.rvalid |-> axil_rsp.rresp == AXIL_RESP_OKAY)
    else begin
        proto_errors++;
        $display("Read response at %0t is not OKAY", $time);
    end

    b_held: assert property (@(posedge aclk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        proto_errors++;
        $display("Write response at %0t dropped before it was accepted", $time);
    end

    r_held: assert property (@(posedge aclk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
        proto_errors++;
        $display("Read response at %0t changed before it was accepted", $time);
    end

    // Constant stream gives one pulse every HOLDOFF_CLOCKS + 1 clocks
    holdoff_b0: assert property (@(posedge aclk) disable iff (!rst_n)
        holdoff_phase && trigger_o[0] |-> ##(HOLDOFF_CLOCKS + 1) trigger_o[0])
    else begin
        value_errors++;
        $display("Fail at %0t: beam 0 holdoff period wrong", $time);
    end

    holdoff_b1: assert property (@(posedge aclk) disable iff (!rst_n)
        holdoff_phase && trigger_o[1] |-> ##(HOLDOFF_CLOCKS + 1) trigger_o[1])
    else begin
        value_errors++;
        $display("Fail at %0t: beam 1 holdoff period wrong", $time);
    end

    //////////////////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////////////////

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                             input logic [3:0] strb);
        @(posedge aclk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        do @(posedge aclk); while (!(axil_rsp.awready && axil_rsp.wready));
        wr_acc_time = $time;
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        // Stall the response for a while
        repeat ($urandom_range(0, 3)) @(posedge aclk);
        axil_req.bready <= 1'b1;
        do @(posedge aclk); while (!axil_rsp.bvalid);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
        @(posedge aclk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        do @(posedge aclk); while (!axil_rsp.arready);
        rd_acc_time = $time;
        axil_req.arvalid <= 1'b0;
        repeat ($urandom_range(0, 3)) @(posedge aclk);
        axil_req.rready <= 1'b1;
        do @(posedge aclk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        axil_req.rready <= 1'b0;
    endtask

    task automatic expect_reg(input axil_addr_t addr, input axil_data_t exp_val);
        axil_data_t got;
        read_reg(addr, got);
        assert (got == exp_val) else begin
            value_errors++;
            $display("Fail at %0t: read 0x%0h gave 0x%0h expected 0x%0h",
                     $time, addr, got, exp_val);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
    endtask

    //////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////

    initial begin
        axil_data_t rd;
        longint     start_time;
        int         polls;
        logic       done_exp;
        void'($urandom(29));
        rst_n         = 1'b0;
        samples       = '0;
        axil_req      = '0;
        mode          = 0;
        value_errors  = 0;
        proto_errors  = 0;
        holdoff_phase = 1'b0;
        count_en      = 1'b0;
        wr_acc_time   = 0;
        rd_acc_time   = 0;
        for (int b = 0; b < NUM_BEAMS; b++) begin
            pulse_cnt[b]   = 0;
            hold_pulses[b] = 0;
        end
        wait_cycles(10);
        rst_n <= 1'b1;
        wait_cycles(2);

        // Reset state and register map
        assert (trigger_o == '0 && !axil_rsp.bvalid && !axil_rsp.rvalid) else begin
            value_errors++;
            $display("Fail at %0t: outputs not idle after reset", $time);
        end
        expect_reg(REG_THRESH_BASE, axil_data_t'(stage_m[0]));
        write_reg(REG_THRESH_BASE, 32'h1234_5678, 4'b0101);
        expect_reg(REG_THRESH_BASE, axil_data_t'(stage_m[0]));
        write_reg(REG_THRESH_BASE + 8'h4, 32'h0000_ABCD, 4'b0010);
        expect_reg(REG_THRESH_BASE + 8'h4, axil_data_t'(stage_m[1]));
        expect_reg(8'h08, '0);
        expect_reg(8'h30, '0);
        write_reg(REG_COUNT_BASE, 32'hDEAD_BEEF, 4'hF);
        expect_reg(REG_COUNT_BASE, '0);
        expect_reg(REG_COUNT_BASE + 8'h4, '0);

        // Staged level has no effect until the update command
        write_reg(REG_THRESH_BASE, 32'd20, 4'hF);
        write_reg(REG_THRESH_BASE + 8'h4, 32'd20, 4'hF);
        mode <= 1;
        wait_cycles(200);
        write_reg(REG_CTRL, 32'h2, 4'h1);
        wait_cycles(300);

        // Mid-range levels with random input
        write_reg(REG_THRESH_BASE, 32'd300, 4'hF);
        write_reg(REG_THRESH_BASE + 8'h4, 32'd450, 4'hF);
        write_reg(REG_CTRL, 32'h2, 4'h1);
        wait_cycles(400);

        // Holdoff with a constant loud stream
        mode <= 2;
        wait_cycles(10);
        holdoff_phase <= 1'b1;
        wait_cycles(120);
        holdoff_phase <= 1'b0;
        wait_cycles(20);
        for (int b = 0; b < NUM_BEAMS; b++) begin
            assert (hold_pulses[b] >= 2) else begin
                value_errors++;
                $display("Fail at %0t: beam %0d gave %0d holdoff pulses",
                         $time, b, hold_pulses[b]);
            end
        end
        mode <= 0;
        wait_cycles(20);

        // Rate window with a burst in the middle
        write_reg(REG_THRESH_BASE, 32'd100, 4'hF);
        write_reg(REG_THRESH_BASE + 8'h4, 32'd100, 4'hF);
        write_reg(REG_CTRL, 32'h2, 4'h1);
        wait_cycles(10);
        count_en <= 1'b1;
        write_reg(REG_CTRL, 32'h1, 4'h1);
        start_time = wr_acc_time;
        expect_reg(REG_CTRL, '0);
        wait_cycles(100);
        mode <= 1;
        wait_cycles(400);
        mode <= 0;
        polls = 0;
        rd    = '0;
        while (rd[0] == 1'b0 && polls < 2000) begin
            read_reg(REG_CTRL, rd);
            polls++;
            // Start pulse, full window, then done, before the read samples it
            done_exp = ((rd_acc_time - start_time) / CLK_PERIOD) >= (RATE_PERIOD_CLOCKS + 2);
            assert (rd[0] == done_exp) else begin
                value_errors++;
                $display("Fail at %0t: done flag %0b expected %0b", $time, rd[0], done_exp);
            end
        end
        count_en <= 1'b0;
        assert (rd[0]) else begin
            value_errors++;
            $display("Window done flag never set after %0d reads", polls);
        end
        expect_reg(REG_COUNT_BASE, axil_data_t'(pulse_cnt[0]));
        expect_reg(REG_COUNT_BASE + 8'h4, axil_data_t'(pulse_cnt[1]));
        assert (pulse_cnt[0] > 0 && pulse_cnt[1] > 0) else begin
            value_errors++;
            $display("Fail at %0t: burst produced no triggers", $time);
        end

        $display("Value errors %0d, protocol errors %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o
);

    // Half of the 4 ns period
    localparam realtime HALF_PERIOD = 2.0;

    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

// ==== logic/l1_trigger_top.sv ====
`timescale 1ns/100ps

module l1_trigger_top (
    input  logic                       aclk,
    input  logic                       rst_n_i,
    input  l1_trig_pkg::chan_samples_t samples_i,
    input  l1_trig_pkg::axil_req_t     axil_req_i,
    output l1_trig_pkg::axil_rsp_t     axil_rsp_o,
    output l1_trig_pkg::beam_mask_t    trigger_o
);
    import l1_trig_pkg::*;

    ////////////////////////////////////////////////////////////
    // Register block to trigger path
    ////////////////////////////////////////////////////////////

    threshold_t [NUM_BEAMS-1:0] thresh_stage;
    logic                       thresh_update;
    logic                       rate_start;
    count_t     [NUM_BEAMS-1:0] counts;
    logic                       count_done;

    // Datapath between trigger stages
    beam_sum_t  [NUM_BEAMS-1:0] beam_sums;
    beam_mask_t                 raw_trig;

    l1_trigger_regs l1_trigger_regs_inst (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .axil_req_i      (axil_req_i),
        .axil_rsp_o      (axil_rsp_o),
        .thresh_stage_o  (thresh_stage),
        .thresh_update_o (thresh_update),
        .rate_start_o    (rate_start),
        .counts_i        (counts),
        .count_done_i    (count_done)
    );

    // Sum, power and compare each take one clock
    beam_former beam_former_inst (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .samples_i   (samples_i),
        .beam_sums_o (beam_sums)
    );

    beam_discriminator beam_discriminator_inst (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .beam_sums_i     (beam_sums),
        .thresh_stage_i  (thresh_stage),
        .thresh_update_i (thresh_update),
        .raw_trig_o      (raw_trig)
    );

    // Holdoff gate adds no register
    trigger_rate_counter trigger_rate_counter_inst (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .raw_trig_i   (raw_trig),
        .rate_start_i (rate_start),
        .trigger_o    (trigger_o),
        .counts_o     (counts),
        .count_done_o (count_done)
    );

endmodule

// ==== logic/l1_trigger_regs.sv ====
`timescale 1ns/100ps

module l1_trigger_regs (
    input  logic                                                 aclk,
    input  logic                                                 rst_n_i,
    input  l1_trig_pkg::axil_req_t                               axil_req_i,
    output l1_trig_pkg::axil_rsp_t                               axil_rsp_o,
    output l1_trig_pkg::threshold_t [l1_trig_pkg::NUM_BEAMS-1:0] thresh_stage_o,
    output logic                                                 thresh_update_o,
    output logic                                                 rate_start_o,
    input  l1_trig_pkg::count_t     [l1_trig_pkg::NUM_BEAMS-1:0] counts_i,
    input  logic                                                 count_done_i
);
    import l1_trig_pkg::*;

    // Handshake state
    logic       wr_accept;
    logic       rd_accept;
    logic       bvalid;
    logic       rvalid;
    // Write to the low byte of CTRL
    logic       ctrl_wr;
    // Read data
    axil_data_t rd_data_next;
    axil_data_t rdata;

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    // Address and data must arrive together, no write while B is pending
    assign wr_accept = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid;
    assign ctrl_wr   = wr_accept && (axil_req_i.awaddr == REG_CTRL)
                       && axil_req_i.wstrb[0];

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (axil_req_i.bready) begin
            bvalid <= 1'b0;
        end
    end

    // Command pulses one clock after acceptance
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            rate_start_o    <= 1'b0;
            thresh_update_o <= 1'b0;
        end else begin
            rate_start_o    <= ctrl_wr && axil_req_i.wdata[0];
            thresh_update_o <= ctrl_wr && axil_req_i.wdata[1];
        end
    end

    // Staged thresholds, byte lanes under wstrb
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            thresh_stage_o <= {NUM_BEAMS{THRESH_RESET}};
        end else if (wr_accept) begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                if (axil_req_i.awaddr == axil_addr_t'(REG_THRESH_BASE + b * REG_STRIDE)) begin
                    if (axil_req_i.wstrb[0]) begin
                        thresh_stage_o[b][7:0] <= axil_req_i.wdata[7:0];
                    end
                    if (axil_req_i.wstrb[1]) begin
                        thresh_stage_o[b][15:8] <= axil_req_i.wdata[15:8];
                    end
                    // Top byte only carries two bits
                    if (axil_req_i.wstrb[2]) begin
                        thresh_stage_o[b][POWER_W-1:16] <= axil_req_i.wdata[POWER_W-1:16];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    assign rd_accept = axil_req_i.arvalid && !rvalid;

    // Unmapped addresses fall through as zero
    always_comb begin
        rd_data_next = '0;
        if (axil_req_i.araddr == REG_CTRL) begin
            rd_data_next[0] = count_done_i;
        end
        for (int b = 0; b < NUM_BEAMS; b++) begin
            if (axil_req_i.araddr == axil_addr_t'(REG_THRESH_BASE + b * REG_STRIDE)) begin
                rd_data_next = axil_data_t'(thresh_stage_o[b]);
            end
            if (axil_req_i.araddr == axil_addr_t'(REG_COUNT_BASE + b * REG_STRIDE)) begin
                rd_data_next = axil_data_t'(counts_i[b]);
            end
        end
    end

    // Data captured at acceptance, held until rready
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
            rdata  <= rd_data_next;
        end else if (axil_req_i.rready) begin
            rvalid <= 1'b0;
        end
    end

    // Response bundle
    always_comb begin
        axil_rsp_o.awready = wr_accept;
        axil_rsp_o.wready  = wr_accept;
        axil_rsp_o.bvalid  = bvalid;
        axil_rsp_o.bresp   = AXIL_RESP_OKAY;
        axil_rsp_o.arready = !rvalid;
        axil_rsp_o.rvalid  = rvalid;
        axil_rsp_o.rdata   = rdata;
        axil_rsp_o.rresp   = AXIL_RESP_OKAY;
    end

endmodule

// ==== trigger/trigger_rate_counter.sv ====
`timescale 1ns/100ps

module trigger_rate_counter (
    input  logic                                             aclk,
    input  logic                                             rst_n_i,
    input  l1_trig_pkg::beam_mask_t                          raw_trig_i,
    input  logic                                             rate_start_i,
    output l1_trig_pkg::beam_mask_t                          trigger_o,
    output l1_trig_pkg::count_t [l1_trig_pkg::NUM_BEAMS-1:0] counts_o,
    output logic                                             count_done_o
);
    import l1_trig_pkg::*;

    // Remaining blocked clocks per beam
    logic [NUM_BEAMS-1:0][HOLDOFF_W-1:0] holdoff;
    // Window timer and its run flag
    logic [WINDOW_W-1:0]                 window_cnt;
    logic                                window_run;
    logic                                window_last;

    ////////////////////////////////////////////////////////////
    // Holdoff gating
    ////////////////////////////////////////////////////////////

    // Raw trigger passes only while the beam is not held off
    always_comb begin
        for (int b = 0; b < NUM_BEAMS; b++) begin
            trigger_o[b] = raw_trig_i[b] && (holdoff[b] == '0);
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            holdoff <= '0;
        end else begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                if (rate_start_i) begin
                    holdoff[b] <= '0;
                end else if (trigger_o[b]) begin
                    // Reload on every passed pulse
                    holdoff[b] <= HOLDOFF_W'(HOLDOFF_CLOCKS);
                end else if (holdoff[b] != '0) begin
                    holdoff[b] <= holdoff[b] - 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Measurement window and per-beam counts
    ////////////////////////////////////////////////////////////

    assign window_last = (window_cnt == WINDOW_W'(RATE_PERIOD_CLOCKS - 1));

    // Shared timer for all beams
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            window_run   <= 1'b0;
            window_cnt   <= '0;
            count_done_o <= 1'b0;
        end else if (rate_start_i) begin
            window_run   <= 1'b1;
            window_cnt   <= '0;
            count_done_o <= 1'b0;
        end else if (window_run) begin
            window_cnt <= window_cnt + 1'b1;
            // Done shows up the clock after the final window clock
            if (window_last) begin
                window_run   <= 1'b0;
                count_done_o <= 1'b1;
            end
        end
    end

    // Only gated triggers inside the window are counted
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            counts_o <= '0;
        end else if (rate_start_i) begin
            counts_o <= '0;
        end else if (window_run) begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                if (trigger_o[b]) begin
                    counts_o[b] <= counts_o[b] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== trigger/beam_discriminator.sv ====
`timescale 1ns/100ps

module beam_discriminator (
    input  logic                                                 aclk,
    input  logic                                                 rst_n_i,
    input  l1_trig_pkg::beam_sum_t  [l1_trig_pkg::NUM_BEAMS-1:0] beam_sums_i,
    input  l1_trig_pkg::threshold_t [l1_trig_pkg::NUM_BEAMS-1:0] thresh_stage_i,
    input  logic                                                 thresh_update_i,
    output l1_trig_pkg::beam_mask_t                              raw_trig_o
);
    import l1_trig_pkg::*;

    // Full width square of each beam sum
    logic       [NUM_BEAMS-1:0][SQUARE_W-1:0] square;
    // Registered beam power
    power_t     [NUM_BEAMS-1:0]               power;
    // Levels in use by the compare
    threshold_t [NUM_BEAMS-1:0]               thresh_active;

    ////////////////////////////////////////////////////////////
    // Power stage
    ////////////////////////////////////////////////////////////

    always_comb begin
        beam_sum_t sum;
        for (int b = 0; b < NUM_BEAMS; b++) begin
            sum       = beam_sums_i[b];
            // Signed product, never negative
            square[b] = sum * sum;
        end
    end

    // Power lands one clock after the sum
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            power <= '0;
        end else begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                power[b] <= power_t'(square[b]);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Threshold update and compare
    ////////////////////////////////////////////////////////////

    // All beams take their staged level together
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            thresh_active <= {NUM_BEAMS{THRESH_RESET}};
        end else if (thresh_update_i) begin
            thresh_active <= thresh_stage_i;
        end
    end

    // Strictly above the active level fires the raw trigger
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            raw_trig_o <= '0;
        end else begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                raw_trig_o[b] <= (power[b] > thresh_active[b]);
            end
        end
    end

endmodule

// ==== trigger/beam_former.sv ====
`timescale 1ns/100ps

module beam_former (
    input  logic                                                aclk,
    input  logic                                                rst_n_i,
    input  l1_trig_pkg::chan_samples_t                          samples_i,
    output l1_trig_pkg::beam_sum_t [l1_trig_pkg::NUM_BEAMS-1:0] beam_sums_o
);
    import l1_trig_pkg::*;

    ////////////////////////////////////////////////////////////
    // Channel delay lines
    ////////////////////////////////////////////////////////////

    // Per channel history, entry 0 is one clock old
    sample_t [NUM_CHANNELS-1:0][MAX_DELAY-1:0] history;
    // History with the live sample at index 0
    sample_t [NUM_CHANNELS-1:0][MAX_DELAY:0]   taps;
    // Unregistered sums for every beam
    beam_sum_t [NUM_BEAMS-1:0]                 sums_next;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            history <= '0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                // Shift one step deeper each clock
                history[c][0] <= samples_i[c];
                for (int d = 1; d < MAX_DELAY; d++) begin
                    history[c][d] <= history[c][d-1];
                end
            end
        end
    end

    // Delay d picks taps[c][d]
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            taps[c] = {history[c], samples_i[c]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Delay-and-sum per beam
    ////////////////////////////////////////////////////////////

    always_comb begin
        sample_t tap;
        for (int b = 0; b < NUM_BEAMS; b++) begin
            sums_next[b] = '0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                // Channel sample at this beam's steering delay
                tap          = taps[c][BEAM_DELAYS[b][c]];
                // Sign extended into the wider sum
                sums_next[b] = sums_next[b] + beam_sum_t'(tap);
            end
        end
    end

    // One clock after the newest sample in the sum
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            beam_sums_o <= '0;
        end else begin
            beam_sums_o <= sums_next;
        end
    end

endmodule

// ==== common/l1_trig_pkg.sv ====
package l1_trig_pkg;

    ////////////////////////////////////////////////////////////
    // Array geometry and datapath widths
    ////////////////////////////////////////////////////////////

    localparam int NUM_CHANNELS = 4;
    localparam int NUM_BEAMS    = 2;

    localparam int SAMPLE_W = 5;
    // Sum of four 5-bit samples fits in 7 bits, one spare
    localparam int SUM_W    = 8;
    localparam int SQUARE_W = 2 * SUM_W;
    // Power and threshold share this width
    localparam int POWER_W  = 18;
    localparam int COUNT_W  = 32;

    // Delay in clocks per beam, then per channel
    localparam int BEAM_DELAYS [NUM_BEAMS][NUM_CHANNELS] = '{
        '{0, 0, 0, 0},
        '{0, 1, 2, 3}
    };
    // Largest entry of the delay table
    localparam int MAX_DELAY = 3;

    // Trigger holdoff and measurement window
    localparam int HOLDOFF_CLOCKS     = 16;
    localparam int HOLDOFF_W          = $clog2(HOLDOFF_CLOCKS + 1);
    localparam int RATE_PERIOD_CLOCKS = 1024;
    localparam int WINDOW_W           = $clog2(RATE_PERIOD_CLOCKS);

    typedef logic signed [SAMPLE_W-1:0]      sample_t;
    typedef sample_t     [NUM_CHANNELS-1:0]  chan_samples_t;
    typedef logic signed [SUM_W-1:0]         beam_sum_t;
    typedef logic        [POWER_W-1:0]       power_t;
    typedef logic        [POWER_W-1:0]       threshold_t;
    typedef logic        [NUM_BEAMS-1:0]     beam_mask_t;
    typedef logic        [COUNT_W-1:0]       count_t;

    // All ones so nothing fires before the host programs a level
    localparam threshold_t THRESH_RESET = '1;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite register port
    ////////////////////////////////////////////////////////////

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    // Byte addresses, one word per beam above each base
    localparam axil_addr_t REG_CTRL        = 8'h00;
    localparam axil_addr_t REG_THRESH_BASE = 8'h10;
    localparam axil_addr_t REG_COUNT_BASE  = 8'h20;
    localparam int         REG_STRIDE      = 4;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // Host side of the bus
    typedef struct packed {
        logic                   awvalid;
        axil_addr_t             awaddr;
        logic                   wvalid;
        axil_data_t             wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   bready;
        logic                   arvalid;
        axil_addr_t             araddr;
        logic                   rready;
    } axil_req_t;

    // Target side of the bus
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage
